// File: include/afu_csr_map.svh
// Host register file offsets

`ifndef afu_csr_map_svh
`define afu_csr_map_svh

// Width of the host register address
localparam int csr_addr_w = 4;

// Base line address of the device status memory
localparam logic [csr_addr_w-1:0] csr_dsm_base = 4'd0;

// Base line address of the pattern destination buffer
localparam logic [csr_addr_w-1:0] csr_dst_base = 4'd1;

// Number of lines in the next pattern job
localparam logic [csr_addr_w-1:0] csr_num_lines = 4'd2;

// Seed word of the generated pattern
localparam logic [csr_addr_w-1:0] csr_seed = 4'd3;

// Control register, bit 0 starts a job
localparam logic [csr_addr_w-1:0] csr_ctl = 4'd4;

`endif

// File: hw/afu_pkg.sv
// Shared widths, request kinds and status
// signature words for the write-side AFU

package afu_pkg;

   // ====================
   // Line and word geometry
   // ====================

   // One cache line on the link
   localparam int line_w = 512;

   // One data word inside a line
   localparam int word_w = 32;

   // Words that make up one line
   localparam int words_per_line = line_w / word_w;

   // Line addresses count cache lines and not bytes
   localparam int addr_w = 32;

   // Job line count and the running total share this width
   localparam int count_w = 16;

   // ====================
   // Transmit request kinds
   // ====================

   // Only full-line writes are issued by this design
   // The other codes are kept free for later request kinds
   typedef enum logic [1:0] {
      wr_line   = 2'b00,
      req_rsvd1 = 2'b01,
      req_rsvd2 = 2'b10,
      req_rsvd3 = 2'b11
   } req_type_t;

   // ====================
   // Status line layout
   // ====================

   // Number of fixed signature words at the start of a status line
   localparam int status_sig_words = 4;

   // Signature words that let the host recognise a valid status line
   localparam logic [word_w-1:0] status_sig [status_sig_words] = '{
      32'haced0000,
      32'haced0001,
      32'haced0002,
      32'haced0003
   };

   // Word positions of the running total and the done flag
   localparam int status_total_word = 4;
   localparam int status_done_word  = 5;

endpackage

// File: hw/afu_csr.sv
// Host register file

`timescale 1ns/100ps

`include "afu_csr_map.svh"

module afu_csr
   import afu_pkg::*;
(
   input  logic                  clk,
   input  logic                  resetb,
   // Host register write strobe with its address and data
   input  logic                  csr_write,
   input  logic [csr_addr_w-1:0] csr_addr,
   input  logic [word_w-1:0]     csr_data,
   // High while the pattern writer runs a job
   input  logic                  busy,
   output logic [addr_w-1:0]     dsm_base,
   output logic                  dsm_base_valid,
   output logic [addr_w-1:0]     dst_base,
   output logic [count_w-1:0]    num_lines,
   output logic [word_w-1:0]     seed,
   output logic                  start
);

   // A control write that asks for a new job
   logic start_write;

   // Bit 0 of the control register requests a start
   assign start_write = csr_write && (csr_addr == csr_ctl) && csr_data[0];

   // ====================
   // Control state
   // ====================

   // The valid flag only clears on reset
   // The start pulse is dropped while a job runs or one was just issued
   always_ff @(posedge clk) begin
      if (!resetb) begin
         dsm_base_valid <= 1'b0;
         start          <= 1'b0;
      end else begin
         if (csr_write && (csr_addr == csr_dsm_base)) begin
            dsm_base_valid <= 1'b1;
         end
         start <= start_write && !busy && !start;
      end
   end

   // ====================
   // Held job parameters
   // ====================

   // Plain data registers, loaded by their own offset
   always_ff @(posedge clk) begin
      if (csr_write) begin
         case (csr_addr)
            csr_dsm_base: begin
               dsm_base <= csr_data[addr_w-1:0];
            end
            csr_dst_base: begin
               dst_base <= csr_data[addr_w-1:0];
            end
            csr_num_lines: begin
               num_lines <= csr_data[count_w-1:0];
            end
            csr_seed: begin
               seed <= csr_data;
            end
            default: begin
               // Control and unused offsets hold no data
            end
         endcase
      end
   end

endmodule

// File: hw/status_writer.sv
// Device status line writer

`timescale 1ns/100ps

module status_writer
   import afu_pkg::*;
(
   input  logic               clk,
   input  logic               resetb,
   input  logic [addr_w-1:0]  dsm_base,
   input  logic               dsm_base_valid,
   // End of a pattern job and the line count of that job
   input  logic               job_done,
   input  logic [count_w-1:0] num_lines,
   input  logic               status_grant,
   output logic               status_req,
   output logic [addr_w-1:0]  status_addr,
   output logic [line_w-1:0]  status_data
);

   typedef enum logic [1:0] {st_idle, st_req, st_wait} state_t;

   state_t state;
   state_t state_nxt;

   // Delayed valid flag, used to spot the first time the base is set
   logic valid_q;
   // A job ended while a status write was still waiting for its grant
   logic pending;
   logic [count_w-1:0] total;
   logic done_flag;

   // ====================
   // FSM
   // ====================

   always_comb begin
      state_nxt = state;
      case (state)
         st_idle: begin
            // Only the first rise of the valid flag starts the writer
            if (dsm_base_valid && !valid_q) begin
               state_nxt = st_req;
            end
         end
         st_req: begin
            // A job that ended meanwhile gets a write of its own
            if (status_grant) begin
               state_nxt = (pending || job_done) ? st_req : st_wait;
            end
         end
         st_wait: begin
            if (job_done) begin
               state_nxt = st_req;
            end
         end
         default: begin
            state_nxt = st_idle;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!resetb) begin
         state     <= st_idle;
         valid_q   <= 1'b0;
         pending   <= 1'b0;
         total     <= '0;
         done_flag <= 1'b0;
      end else begin
         state   <= state_nxt;
         valid_q <= dsm_base_valid;
         if (state == st_req && status_grant) begin
            pending <= 1'b0;
         end else if (state == st_req && job_done) begin
            pending <= 1'b1;
         end
         // Every finished job adds to the total and marks the line as done
         if (job_done) begin
            total     <= total + num_lines;
            done_flag <= 1'b1;
         end
      end
   end

   // ====================
   // Status line
   // ====================

   assign status_req  = (state == st_req);
   assign status_addr = dsm_base;

   // Signatures first, then the total and the done flag, the rest is zero
   always_comb begin
      status_data = '0;
      for (int i = 0; i < status_sig_words; i++) begin
         status_data[i*word_w +: word_w] = status_sig[i];
      end
      status_data[status_total_word*word_w +: word_w] = word_w'(total);
      status_data[status_done_word*word_w +: word_w]  = word_w'(done_flag);
   end

endmodule

// File: hw/pattern_writer.sv
// Pattern job engine that fills the destination
// buffer with generated lines

`timescale 1ns/100ps

module pattern_writer
   import afu_pkg::*;
(
   input  logic               clk,
   input  logic               resetb,
   input  logic               start,
   input  logic [addr_w-1:0]  dst_base,
   input  logic [count_w-1:0] num_lines,
   input  logic [word_w-1:0]  seed,
   input  logic               pattern_grant,
   output logic               pattern_req,
   output logic [addr_w-1:0]  pattern_addr,
   output logic [line_w-1:0]  pattern_data,
   output logic               busy,
   output logic               job_done
);

   // Job parameters captured at start
   logic [addr_w-1:0]  base_q;
   logic [count_w-1:0] len_q;
   logic [word_w-1:0]  seed_q;

   // Index of the line that is being requested
   logic [count_w-1:0] idx;

   // First word of the current line
   logic [word_w-1:0] line_word0;

   // ====================
   // Job control
   // ====================

   // Busy is the request itself, one line is offered per grant
   always_ff @(posedge clk) begin
      if (!resetb) begin
         busy     <= 1'b0;
         job_done <= 1'b0;
      end else begin
         job_done <= 1'b0;
         if (start) begin
            // An empty job ends at once without a single line
            if (num_lines == '0) begin
               job_done <= 1'b1;
            end else begin
               busy <= 1'b1;
            end
         end else if (busy && pattern_grant && (idx == len_q - 1'b1)) begin
            busy     <= 1'b0;
            job_done <= 1'b1;
         end
      end
   end

   // The line index restarts with each job and steps on every grant
   always_ff @(posedge clk) begin
      if (start) begin
         base_q <= dst_base;
         len_q  <= num_lines;
         seed_q <= seed;
         idx    <= '0;
      end else if (busy && pattern_grant) begin
         idx <= idx + 1'b1;
      end
   end

   // ====================
   // Line generation
   // ====================

   assign pattern_req  = busy;
   assign pattern_addr = base_q + addr_w'(idx);

   // Word j of line i carries seed plus i times the line size plus j
   assign line_word0 = seed_q + word_w'(idx) * word_w'(words_per_line);

   always_comb begin
      for (int j = 0; j < words_per_line; j++) begin
         pattern_data[j*word_w +: word_w] = line_word0 + word_w'(j);
      end
   end

endmodule

// File: hw/write_arbiter.sv
// Round-robin write arbiter and the registered
// transmit channel

`timescale 1ns/100ps

module write_arbiter
   import afu_pkg::*;
(
   input  logic              clk,
   input  logic              resetb,
   input  logic              status_req,
   input  logic [addr_w-1:0] status_addr,
   input  logic [line_w-1:0] status_data,
   input  logic              pattern_req,
   input  logic [addr_w-1:0] pattern_addr,
   input  logic [line_w-1:0] pattern_data,
   // Link back-pressure, no grant while it is high
   input  logic              tx_almost_full,
   output logic              status_grant,
   output logic              pattern_grant,
   output logic              tx_valid,
   output req_type_t         tx_type,
   output logic [addr_w-1:0] tx_addr,
   output logic [line_w-1:0] tx_data
);

   // Set when the status writer won the last grant
   logic last_status;

   // ====================
   // Grant logic
   // ====================

   // With both writers requesting, the one not served last time wins
   assign status_grant  = !tx_almost_full && status_req &&
                          (!pattern_req || !last_status);
   assign pattern_grant = !tx_almost_full && pattern_req &&
                          (!status_req || last_status);

   always_ff @(posedge clk) begin
      if (!resetb) begin
         last_status <= 1'b0;
         tx_valid    <= 1'b0;
      end else begin
         if (status_grant) begin
            last_status <= 1'b1;
         end else if (pattern_grant) begin
            last_status <= 1'b0;
         end
         // One transmit cycle follows every grant
         tx_valid <= status_grant || pattern_grant;
      end
   end

   // ====================
   // Transmit payload
   // ====================

   // The header and line are taken from the granted writer only
   always_ff @(posedge clk) begin
      if (status_grant) begin
         tx_type <= wr_line;
         tx_addr <= status_addr;
         tx_data <= status_data;
      end else if (pattern_grant) begin
         tx_type <= wr_line;
         tx_addr <= pattern_addr;
         tx_data <= pattern_data;
      end
   end

endmodule

// File: hw/afu_top.sv
// AFU write side top level

`timescale 1ns/100ps

`include "afu_csr_map.svh"

module afu_top
   import afu_pkg::*;
(
   input  logic                  clk,
   input  logic                  resetb,
   // Host register writes
   input  logic                  csr_write,
   input  logic [csr_addr_w-1:0] csr_addr,
   input  logic [word_w-1:0]     csr_data,
   // Transmit channel towards host memory
   input  logic                  tx_almost_full,
   output logic                  tx_valid,
   output req_type_t             tx_type,
   output logic [addr_w-1:0]     tx_addr,
   output logic [line_w-1:0]     tx_data
);

   // Register file outputs
   logic [addr_w-1:0]  dsm_base;
   logic               dsm_base_valid;
   logic [addr_w-1:0]  dst_base;
   logic [count_w-1:0] num_lines;
   logic [word_w-1:0]  seed;
   logic               start;

   // Job handshake between the pattern writer and the rest
   logic busy;
   logic job_done;

   // Writer requests and arbiter grants
   logic              status_req;
   logic [addr_w-1:0] status_addr;
   logic [line_w-1:0] status_data;
   logic              status_grant;
   logic              pattern_req;
   logic [addr_w-1:0] pattern_addr;
   logic [line_w-1:0] pattern_data;
   logic              pattern_grant;

   afu_csr u_csr (
      .clk            (clk),
      .resetb         (resetb),
      .csr_write      (csr_write),
      .csr_addr       (csr_addr),
      .csr_data       (csr_data),
      .busy           (busy),
      .dsm_base       (dsm_base),
      .dsm_base_valid (dsm_base_valid),
      .dst_base       (dst_base),
      .num_lines      (num_lines),
      .seed           (seed),
      .start          (start)
   );

   // The status writer reads the job length from the register file
   status_writer u_status_writer (
      .clk            (clk),
      .resetb         (resetb),
      .dsm_base       (dsm_base),
      .dsm_base_valid (dsm_base_valid),
      .job_done       (job_done),
      .num_lines      (num_lines),
      .status_grant   (status_grant),
      .status_req     (status_req),
      .status_addr    (status_addr),
      .status_data    (status_data)
   );

   pattern_writer u_pattern_writer (
      .clk           (clk),
      .resetb        (resetb),
      .start         (start),
      .dst_base      (dst_base),
      .num_lines     (num_lines),
      .seed          (seed),
      .pattern_grant (pattern_grant),
      .pattern_req   (pattern_req),
      .pattern_addr  (pattern_addr),
      .pattern_data  (pattern_data),
      .busy          (busy),
      .job_done      (job_done)
   );

   write_arbiter u_write_arbiter (
      .clk            (clk),
      .resetb         (resetb),
      .status_req     (status_req),
      .status_addr    (status_addr),
      .status_data    (status_data),
      .pattern_req    (pattern_req),
      .pattern_addr   (pattern_addr),
      .pattern_data   (pattern_data),
      .tx_almost_full (tx_almost_full),
      .status_grant   (status_grant),
      .pattern_grant  (pattern_grant),
      .tx_valid       (tx_valid),
      .tx_type        (tx_type),
      .tx_addr        (tx_addr),
      .tx_data        (tx_data)
   );

endmodule

// File: testbench/tb_clock.sv
// Testbench clock and reset

`timescale 1ns/100ps

module tb_clock (
   output logic clk,
   output logic resetb
);

   // 10 ns period
   initial begin
      clk = 1'b0;
      forever begin
         #5 clk = ~clk;
      end
   end

   // Reset is held low for three rising edges and released just after the third
   initial begin
      resetb = 1'b0;
      repeat (3) @(posedge clk);
      #1 resetb = 1'b1;
   end

endmodule

// File: testbench/afu_checker.sv
// Transmit channel assertions

`timescale 1ns/100ps

module afu_checker (
   input logic clk,
   input logic resetb,
   input logic tx_valid,
   input logic tx_almost_full,
   input logic status_grant,
   input logic pattern_grant
);

   // Count of failed assertions, watched by the testbench every cycle
   int failures = 0;

   // A line goes out only one cycle after a grant, and grants need room on the link
   a_valid_after_room: assert property (@(posedge clk) disable iff (!resetb)
      tx_valid |-> $past(!tx_almost_full))
      else begin
         failures++;
         $error("tx_valid high although tx_almost_full was high one cycle before");
      end

   // The arbiter serves one writer per cycle
   a_one_grant: assert property (@(posedge clk) disable iff (!resetb)
      !(status_grant && pattern_grant))
      else begin
         failures++;
         $error("status_grant and pattern_grant high in the same cycle");
      end

   // The registered channel comes out of reset idle
   a_idle_after_reset: assert property (@(posedge clk)
      $rose(resetb) |-> !tx_valid)
      else begin
         failures++;
         $error("tx_valid high in the first cycle after reset");
      end

endmodule

bind afu_top afu_checker u_checker (
   .clk            (clk),
   .resetb         (resetb),
   .tx_valid       (tx_valid),
   .tx_almost_full (tx_almost_full),
   .status_grant   (status_grant),
   .pattern_grant  (pattern_grant)
);

// File: testbench/afu_tb.sv
// AFU write side testbench

`timescale 1ns/100ps

`include "afu_csr_map.svh"

module afu_tb
   import afu_pkg::*;
();

   localparam int num_jobs = 6;
   localparam int max_len = 12;
   localparam logic [addr_w-1:0] dsm_base_addr = 32'h0000_0800;
   // Every line, status lines included, gets a generous budget of cycles
   localparam int timeout_cycles = 200 * (num_jobs * max_len + num_jobs + 1) + 2000;

   logic                  clk;
   logic                  resetb;
   logic                  csr_write;
   logic [csr_addr_w-1:0] csr_addr;
   logic [word_w-1:0]     csr_data;
   logic                  tx_almost_full;
   logic                  tx_valid;
   req_type_t             tx_type;
   logic [addr_w-1:0]     tx_addr;
   logic [line_w-1:0]     tx_data;

   // Host memory model, one line per written address
   logic [line_w-1:0] host_mem [logic [addr_w-1:0]];

   // Expected state of the running job, set by the stimulus process
   logic [addr_w-1:0]  cur_dst = '0;
   logic [count_w-1:0] cur_len = '0;
   logic [word_w-1:0]  cur_seed = '0;
   logic [count_w-1:0] exp_total = '0;
   logic               exp_done = 1'b0;
   logic               job_active = 1'b0;
   logic               status_seen = 1'b0;
   logic               bp_on = 1'b0;

   int tx_count = 0;
   int status_count = 0;
   int job_lines = 0;
   int line_sum = 0;
   int cycles = 0;

   tb_clock u_clock (
      .clk    (clk),
      .resetb (resetb)
   );

   afu_top dut (
      .clk            (clk),
      .resetb         (resetb),
      .csr_write      (csr_write),
      .csr_addr       (csr_addr),
      .csr_data       (csr_data),
      .tx_almost_full (tx_almost_full),
      .tx_valid       (tx_valid),
      .tx_type        (tx_type),
      .tx_addr        (tx_addr),
      .tx_data        (tx_data)
   );

   // ====================
   // Error reporting
   // ====================

   task automatic stop_run();
      $display("TEST FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic fail_value(string name, logic [63:0] got, logic [63:0] exp);
      $display("Fail %s got %h expected %h", name, got, exp);
      stop_run();
   endtask

   task automatic fail_text(string what);
      $display("%s", what);
      stop_run();
   endtask

   // ====================
   // Host side stimulus
   // ====================

   // One register write, driven 1 ns after the clock edge
   task automatic write_csr(logic [csr_addr_w-1:0] addr, logic [word_w-1:0] data);
      @(posedge clk);
      #1;
      csr_write = 1'b1;
      csr_addr  = addr;
      csr_data  = data;
      @(posedge clk);
      #1;
      csr_write = 1'b0;
   endtask

   // Block until the monitor has seen the next status line
   task automatic wait_status();
      while (!status_seen) begin
         @(posedge clk);
         #1;
      end
      status_seen = 1'b0;
   endtask

   // Status line: signatures, the running total in word 4 and the done flag in word 5
   task automatic check_status();
      for (int j = 0; j < 4; j++) begin
         assert (tx_data[j*32 +: 32] == 32'haced0000 + 32'(j))
            else fail_value($sformatf("status word %0d", j), 64'(tx_data[j*32 +: 32]),
                            64'(32'haced0000 + 32'(j)));
      end
      assert (tx_data[4*32 +: 32] == 32'(exp_total))
         else fail_value("status total", 64'(tx_data[4*32 +: 32]), 64'(exp_total));
      assert (tx_data[5*32 +: 32] == 32'(exp_done))
         else fail_value("status done", 64'(tx_data[5*32 +: 32]), 64'(exp_done));
      // A job is over once its status line is out, so all of its lines must be there
      assert (job_lines == int'(cur_len))
         else fail_value("pattern line count", 64'(job_lines), 64'(cur_len));
      job_active   = 1'b0;
      status_count++;
      status_seen  = 1'b1;
   endtask

   // Pattern line: inside the job's range, written once, word j of line i is seed+16i+j
   task automatic check_pattern();
      logic [addr_w-1:0] offset;
      logic [word_w-1:0] exp_word;
      offset = tx_addr - cur_dst;
      assert (job_active)
         else fail_text($sformatf("Pattern write to %h seen while no job was started",
                                  tx_addr));
      assert (offset < addr_w'(cur_len))
         else fail_value("tx_addr", 64'(tx_addr), 64'(cur_dst));
      assert (!host_mem.exists(tx_addr))
         else fail_text($sformatf("Line address %h was written twice", tx_addr));
      for (int j = 0; j < 16; j++) begin
         exp_word = cur_seed + offset * 32'd16 + 32'(j);
         assert (tx_data[j*32 +: 32] == exp_word)
            else fail_value($sformatf("tx_data word %0d", j), 64'(tx_data[j*32 +: 32]),
                            64'(exp_word));
      end
      job_lines++;
   endtask

   // ====================
   // Link monitor and host memory
   // ====================

   // Outputs are registered, so their values at the edge are the settled ones
   always @(posedge clk) begin
      cycles++;
      assert (cycles < timeout_cycles)
         else fail_text("Timeout, the expected writes did not arrive in time");
      assert (dut.u_checker.failures == 0)
         else fail_text("A transmit channel assertion failed");
      if (resetb && tx_valid) begin
         tx_count++;
         assert (tx_type == wr_line)
            else fail_value("tx_type", 64'(tx_type), 64'(wr_line));
         if (tx_addr == dsm_base_addr) begin
            check_status();
         end else begin
            check_pattern();
         end
         host_mem[tx_addr] = tx_data;
      end
   end

   // Random back-pressure while a job runs
   initial begin
      logic bp_next;
      tx_almost_full = 1'b0;
      forever begin
         @(posedge clk);
         // Decided at the edge, applied a little later with the other inputs
         bp_next = bp_on && ($urandom_range(0, 2) == 0);
         #1;
         tx_almost_full = bp_next;
      end
   end

   // ====================
   // Test sequence
   // ====================

   initial begin
      logic [addr_w-1:0]  dst;
      logic [count_w-1:0] len;
      logic [word_w-1:0]  sd;
      void'($urandom(32'h834b0a3d));
      csr_write = 1'b0;
      csr_addr  = '0;
      csr_data  = '0;
      while (!resetb) begin
         @(posedge clk);
      end

      // First write after the base is set: total zero, done clear
      write_csr(csr_dsm_base, dsm_base_addr);
      wait_status();

      for (int job = 0; job < num_jobs; job++) begin
         len = count_w'($urandom_range(0, max_len));
         dst = 32'h0001_0000 + 32'(job) * 32'h100 + 32'($urandom_range(0, 15));
         sd  = $urandom;
         write_csr(csr_dst_base, dst);
         write_csr(csr_num_lines, 32'(len));
         write_csr(csr_seed, sd);
         cur_dst    = dst;
         cur_len    = len;
         cur_seed   = sd;
         job_lines  = 0;
         line_sum  += int'(len);
         exp_total  = count_w'(line_sum);
         exp_done   = 1'b1;
         job_active = 1'b1;
         bp_on      = 1'b1;
         write_csr(csr_ctl, 32'h1);
         wait_status();
         bp_on = 1'b0;
      end

      // Quiet period to catch any write that should not be there
      repeat (20) @(posedge clk);
      #1;
      assert (tx_count == line_sum + num_jobs + 1)
         else fail_value("tx write count", 64'(tx_count), 64'(line_sum + num_jobs + 1));
      assert (status_count == num_jobs + 1)
         else fail_value("status write count", 64'(status_count), 64'(num_jobs + 1));

      if (dut.u_checker.failures == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: tb.f
+incdir+include
hw/afu_pkg.sv
hw/afu_csr.sv
hw/status_writer.sv
hw/pattern_writer.sv
hw/write_arbiter.sv
hw/afu_top.sv
testbench/tb_clock.sv
testbench/afu_checker.sv
testbench/afu_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0 -Wno-fatal
TOP       = afu_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log

SRCS = $(shell grep -v '^+' $(FILELIST))
HDRS = $(wildcard include/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
